// ==== tb.f ====
+incdir+include
hdl/core_pkg.sv
hdl/instr_decoder.sv
hdl/state_ctrl.sv
hdl/serial_alu.sv
hdl/serial_regfile.sv
hdl/retire_trace.sv
hdl/serial_core.sv
tests/tb_serial_core.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_serial_core -f tb.f -o sim \
   > build.log 2>&1 && ./obj_dir/sim > sim.log 2>&1 || echo "build or simulation failed"
cat sim.log 2>/dev/null
grep -q "PASS: all tests" sim.log && exit 0 || exit 1

// ==== include/core_tb_tasks.svh ====
////////////////////
// Encoding and reference
////////////////////

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] rs1,
                                      input logic [2:0] f3, input logic [2:0] rd);
   return {imm, 2'b00, rs1, f3, 2'b00, rd, OPC_IMM};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] rs2,
                                      input logic [2:0] rs1, input logic [2:0] f3,
                                      input logic [2:0] rd);
   return {f7, 2'b00, rs2, 2'b00, rs1, f3, 2'b00, rd, OPC_REG};
endfunction

// RV32I result for the OP and OP-IMM groups.
function automatic logic [31:0] rv_result(input logic [2:0] f3, input logic alt,
                                          input logic is_imm, input logic [31:0] a,
                                          input logic [31:0] b);
   case (f3)
      3'd0:    return (alt && !is_imm) ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
   endcase
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
   checks++;
   if (exp !== act) begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
   end
endtask

task automatic finish_test(input string name, input int err_before);
   tests_run++;
   $display("%s finished with %0d errors", name, errors - err_before);
endtask

////////////////////
// Bus handling
////////////////////

task automatic fetch(input logic [31:0] word, output logic trap);
   @(negedge clk);
   while (!ibus_cyc) @(negedge clk);
   @(posedge clk);
   ibus_ack <= 1'b1;
   ibus_rdt <= word;
   @(negedge clk);
   trap = trap_taken;   // Combinational with the ack.
   @(posedge clk);
   ibus_ack <= 1'b0;
endtask

// Latency counts the ack cycle as cycle one.
task automatic await_retire(output logic [2:0] addr, output logic [31:0] data, output int lat);
   lat = 1;
   do begin
      @(negedge clk);
      lat++;
   end while (!rd_valid);
   addr = rd_addr;
   data = rd_data;
endtask

task automatic await_idle(input string name);
   int pulses;
   pulses = 0;
   do begin
      @(negedge clk);
      if (rd_valid) pulses++;
   end while (!ibus_cyc);
   checks++;
   if (pulses != 0) begin
      errors++;
      $display("%s: a register write was reported during a trap pass", name);
   end
endtask

task automatic run_op(input string name, input logic [31:0] word, input logic trap_exp,
                      input logic chk_lat, input int lat_exp);
   logic        trap;
   logic [2:0]  addr;
   logic [31:0] data;
   logic [31:0] op_b;
   logic [31:0] exp;
   int          lat;
   op_b = word[5] ? ref_regs[word[22:20]] : {{20{word[31]}}, word[31:20]};
   exp  = rv_result(word[14:12], word[30], !word[5], ref_regs[word[17:15]], op_b);
   fetch(word, trap);
   check_value({name, " trap"}, 32'(trap_exp), 32'(trap));
   await_retire(addr, data, lat);
   check_value({name, " rd"}, 32'(word[9:7]), 32'(addr));
   check_value({name, " data"}, (word[9:7] == 3'd0) ? 32'd0 : exp, data);
   if (chk_lat) check_value({name, " latency"}, 32'(lat_exp), 32'(lat));
   if (word[9:7] != 3'd0) ref_regs[word[9:7]] = exp;
endtask

// ==== tests/tb_serial_core.sv ====
module tb_serial_core;

   import core_pkg::*;

   localparam logic [6:0]  OPC_IMM     = 7'h13;
   localparam logic [6:0]  OPC_REG     = 7'h33;
   localparam logic [31:0] ECALL       = 32'h0000_0073;
   localparam int          RST_CYCLES  = 10;
   localparam int          NUM_INSNS   = 58;   // Instructions fetched by the tests below.
   localparam int          CYCLE_LIMIT = NUM_INSNS * 120 + RST_CYCLES;

   logic              clk;
   logic              rst;
   logic              irq;
   logic              ibus_ack;
   logic [31:0]       ibus_rdt;
   logic              ibus_cyc;
   logic              trap_taken;
   logic              rd_valid;
   logic [REG_AW-1:0] rd_addr;
   logic [XLEN-1:0]   rd_data;

   logic [31:0] ref_regs [NUM_REGS];   // Reference register model.
   integer      seed = 32'h27d9;
   int          errors = 0;
   int          checks = 0;
   int          tests_run = 0;
   int          cycle_count = 0;

   serial_core i_dut (
      .i_clk        (clk),
      .i_rst        (rst),
      .i_irq        (irq),
      .i_ibus_ack   (ibus_ack),
      .i_ibus_rdt   (ibus_rdt),
      .o_ibus_cyc   (ibus_cyc),
      .o_trap_taken (trap_taken),
      .o_rd_valid   (rd_valid),
      .o_rd_addr    (rd_addr),
      .o_rd_data    (rd_data)
   );

   `include "core_tb_tasks.svh"

   initial clk = 1'b0;
   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   ////////////////////
   // Directed tests
   ////////////////////

   task automatic test_reset();
      int e0;
      e0 = errors;
      repeat (5) begin
         @(negedge clk);
         check_value("reset cyc", 32'd1, 32'(ibus_cyc));
         check_value("reset valid", 32'd0, 32'(rd_valid));
         check_value("reset trap", 32'd0, 32'(trap_taken));
      end
      finish_test("test_reset", e0);
   endtask

   task automatic test_alu();
      int          e0;
      logic [31:0] r;
      logic [2:0]  f3;
      logic [2:0]  rd;
      e0 = errors;
      for (int i = 1; i < 8; i++) begin
         r = $random(seed);
         run_op("load", enc_i(r[11:0], 3'd0, 3'd0, 3'(i)), 1'b0, 1'b1, 35);
      end
      for (int i = 0; i < 12; i++) begin
         r = $random(seed);
         case (r[1:0])
            2'd0: f3 = 3'd0;
            2'd1: f3 = 3'd4;
            2'd2: f3 = 3'd6;
            default: f3 = 3'd7;
         endcase
         rd = (r[4:2] == 3'd0) ? 3'd1 : r[4:2];
         if (r[24]) begin
            run_op("alu imm", enc_i(r[22:11], r[7:5], f3, rd), 1'b0, 1'b1, 35);
         end else begin
            run_op("alu reg", enc_r({1'b0, r[23] & (f3 == 3'd0), 5'd0}, r[10:8], r[7:5], f3, rd),
                   1'b0, 1'b1, 35);
         end
      end
      finish_test("test_alu", e0);
   endtask

   task automatic test_compare();
      int e0;
      e0 = errors;
      run_op("load", enc_i(12'd1, 3'd0, 3'd0, 3'd1), 1'b0, 1'b1, 35);
      run_op("load", enc_i(12'd31, 3'd1, 3'd1, 3'd1), 1'b0, 1'b0, 0);     // 0x80000000.
      run_op("load", enc_i(12'hfff, 3'd1, 3'd0, 3'd2), 1'b0, 1'b1, 35);   // 0x7fffffff.
      run_op("load", enc_i(12'hfff, 3'd0, 3'd0, 3'd3), 1'b0, 1'b1, 35);
      run_op("load", enc_i(12'd5, 3'd0, 3'd0, 3'd4), 1'b0, 1'b1, 35);
      run_op("slt min", enc_r(7'd0, 3'd2, 3'd1, 3'd2, 3'd5), 1'b0, 1'b1, 69);
      run_op("sltu min", enc_r(7'd0, 3'd2, 3'd1, 3'd3, 3'd5), 1'b0, 1'b1, 69);
      run_op("slt equal", enc_r(7'd0, 3'd2, 3'd2, 3'd2, 3'd5), 1'b0, 1'b1, 69);
      run_op("sltu neg", enc_r(7'd0, 3'd4, 3'd3, 3'd3, 3'd6), 1'b0, 1'b1, 69);
      run_op("slt neg", enc_r(7'd0, 3'd4, 3'd3, 3'd2, 3'd6), 1'b0, 1'b1, 69);
      run_op("slti equal", enc_i(12'd5, 3'd4, 3'd2, 3'd7), 1'b0, 1'b1, 69);
      run_op("sltiu max", enc_i(12'hfff, 3'd4, 3'd3, 3'd7), 1'b0, 1'b1, 69);
      run_op("slti zero", enc_i(12'd0, 3'd1, 3'd2, 3'd7), 1'b0, 1'b1, 69);
      run_op("sltu x0", enc_r(7'd0, 3'd3, 3'd0, 3'd3, 3'd6), 1'b0, 1'b1, 69);
      finish_test("test_compare", e0);
   endtask

   task automatic test_shift();
      int          e0;
      logic [31:0] r;
      logic [2:0]  f3;
      logic        alt;
      logic [2:0]  rd;
      e0 = errors;
      for (int i = 0; i < 16; i++) begin
         r   = $random(seed);
         f3  = (r[1:0] == 2'd0) ? 3'd1 : 3'd5;
         alt = (r[1:0] >= 2'd2);   // Arithmetic right shift.
         rd  = (r[16:14] == 3'd0) ? 3'd3 : r[16:14];
         if (r[2]) begin
            run_op("shift imm", enc_i({1'b0, alt, 5'd0, r[7:3]}, r[10:8], f3, rd),
                   1'b0, 1'b0, 0);
         end else begin
            run_op("shift reg", enc_r({1'b0, alt, 5'd0}, r[13:11], r[10:8], f3, rd),
                   1'b0, 1'b0, 0);
         end
      end
      finish_test("test_shift", e0);
   endtask

   task automatic test_trap();
      int          e0;
      logic        trap;
      logic [2:0]  addr;
      logic [31:0] data;
      int          lat;
      e0 = errors;
      fetch(ECALL, trap);
      check_value("ecall trap", 32'd0, 32'(trap));
      await_idle("ecall");
      run_op("after ecall", enc_i(12'd5, 3'd0, 3'd0, 3'd1), 1'b1, 1'b1, 35);
      // Interrupt raised while an addi runs.
      fetch(enc_i(12'd7, 3'd0, 3'd0, 3'd2), trap);
      check_value("irq insn trap", 32'd0, 32'(trap));
      @(posedge clk);
      irq <= 1'b1;
      repeat (3) @(posedge clk);
      irq <= 1'b0;
      await_retire(addr, data, lat);
      check_value("irq insn rd", 32'd2, 32'(addr));
      check_value("irq insn data", 32'd7, data);
      check_value("irq insn latency", 32'd35 - 32'd4, 32'(lat));   // Four cycles pass first.
      ref_regs[2] = 32'd7;
      // The next instruction is replaced by the trap pass.
      fetch(enc_i(12'd9, 3'd0, 3'd0, 3'd3), trap);
      check_value("irq boundary trap", 32'd0, 32'(trap));
      await_idle("irq");
      run_op("after irq", enc_i(12'd11, 3'd0, 3'd0, 3'd4), 1'b1, 1'b1, 35);
      finish_test("test_trap", e0);
   endtask

   task automatic test_x0();
      int e0;
      e0 = errors;
      run_op("x0 write", enc_i(12'd123, 3'd1, 3'd0, 3'd0), 1'b0, 1'b1, 35);
      run_op("x0 add", enc_r(7'd0, 3'd1, 3'd0, 3'd0, 3'd5), 1'b0, 1'b1, 35);
      run_op("x0 addi", enc_i(12'hffd, 3'd0, 3'd0, 3'd6), 1'b0, 1'b1, 35);
      run_op("x0 sub", enc_r(7'h20, 3'd6, 3'd0, 3'd0, 3'd7), 1'b0, 1'b1, 35);
      finish_test("test_x0", e0);
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      rst      = 1'b1;
      irq      = 1'b0;
      ibus_ack = 1'b0;
      ibus_rdt = '0;
      for (int i = 0; i < NUM_REGS; i++) ref_regs[i] = '0;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;
      test_reset();
      test_alu();
      test_compare();
      test_shift();
      test_trap();
      test_x0();
      @(negedge clk);
      $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// ==== hdl/serial_core.sv ====
module serial_core
   import core_pkg::*;
(
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_irq,
   input  logic              i_ibus_ack,
   input  logic [31:0]       i_ibus_rdt,
   output logic              o_ibus_cyc,
   output logic              o_trap_taken,
   output logic              o_rd_valid,
   output logic [REG_AW-1:0] o_rd_addr,
   output logic [XLEN-1:0]   o_rd_data
);

   logic              ibus_fetch;
   alu_op_t           alu_op;
   logic              imm_op;
   logic              imm_bit;
   logic [REG_AW-1:0] rs1;
   logic [REG_AW-1:0] rs2;
   logic [REG_AW-1:0] rd;
   logic              rd_op;
   logic              slt_op;
   logic              shift_op;
   logic              e_op;
   logic              rf_ready;
   logic              rf_rreq;
   logic              rf_wreq;
   logic              rf_rd_en;
   state_t            state;
   logic [CNT_W-1:0]  cnt;
   logic              cnt_done;
   logic              stage_two_pending;
   logic              sh_done;
   logic              rs1_bit;
   logic              rs2_bit;
   logic              op_b_bit;
   logic              rd_bit;

   assign ibus_fetch = i_ibus_ack & o_ibus_cyc;     // Stray acks are dropped.
   assign op_b_bit   = imm_op ? imm_bit : rs2_bit;  // Operand B select.

   instr_decoder u_decoder (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ibus_ack (ibus_fetch),
      .i_ibus_rdt (i_ibus_rdt),
      .i_cnt      (cnt),
      .o_alu_op   (alu_op),
      .o_imm_op   (imm_op),
      .o_imm_bit  (imm_bit),
      .o_rs1      (rs1),
      .o_rs2      (rs2),
      .o_rd       (rd),
      .o_rd_op    (rd_op),
      .o_slt_op   (slt_op),
      .o_shift_op (shift_op),
      .o_e_op     (e_op)
   );

   state_ctrl u_state (
      .i_clk               (i_clk),
      .i_rst               (i_rst),
      .i_irq               (i_irq),
      .i_ibus_ack          (ibus_fetch),
      .i_rf_ready          (rf_ready),
      .i_slt_op            (slt_op),
      .i_shift_op          (shift_op),
      .i_e_op              (e_op),
      .i_rd_op             (rd_op),
      .i_alu_sh_done       (sh_done),
      .o_ibus_cyc          (o_ibus_cyc),
      .o_trap_taken        (o_trap_taken),
      .o_rf_rreq           (rf_rreq),
      .o_rf_wreq           (rf_wreq),
      .o_rf_rd_en          (rf_rd_en),
      .o_state             (state),
      .o_cnt               (cnt),
      .o_cnt_r             (),
      .o_cnt_done          (cnt_done),
      .o_stage_two_pending (stage_two_pending)
   );

   serial_alu u_alu (
      .i_clk               (i_clk),
      .i_rst               (i_rst),
      .i_state             (state),
      .i_cnt               (cnt),
      .i_stage_two_pending (stage_two_pending),
      .i_alu_op            (alu_op),
      .i_rs1_bit           (rs1_bit),
      .i_op_b_bit          (op_b_bit),
      .o_sh_done           (sh_done),
      .o_rd_bit            (rd_bit)
   );

   serial_regfile u_regfile (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_rf_rreq  (rf_rreq),
      .i_rf_wreq  (rf_wreq),
      .i_rd_en    (rf_rd_en),
      .i_cnt      (cnt),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_rd       (rd),
      .i_rd_bit   (rd_bit),
      .o_rf_ready (rf_ready),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit)
   );

   retire_trace u_trace (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_rd_en    (rf_rd_en),
      .i_cnt_done (cnt_done),
      .i_rd       (rd),
      .i_rd_bit   (rd_bit),
      .o_rd_valid (o_rd_valid),
      .o_rd_addr  (o_rd_addr),
      .o_rd_data  (o_rd_data)
   );

endmodule

// ==== hdl/retire_trace.sv ====
module retire_trace
   import core_pkg::*;
(
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_rd_en,
   input  logic              i_cnt_done,
   input  logic [REG_AW-1:0] i_rd,
   input  logic              i_rd_bit,
   output logic              o_rd_valid,
   output logic [REG_AW-1:0] o_rd_addr,
   output logic [XLEN-1:0]   o_rd_data
);

   logic [XLEN-1:0]   data_sr;
   logic [REG_AW-1:0] rd_q;

   always_ff @(posedge i_clk) begin
      if (i_rd_en) begin
         data_sr <= {i_rd_bit, data_sr[XLEN-1:1]};   // Bit 0 ends up at the bottom.
         rd_q    <= i_rd;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_rd_valid <= 1'b0;
      end else begin
         o_rd_valid <= i_rd_en & i_cnt_done;   // After the last bit of a write.
      end
   end

   assign o_rd_addr = rd_q;
   assign o_rd_data = (rd_q == '0) ? '0 : data_sr;   // x0 reads as zero.

endmodule

// ==== hdl/serial_regfile.sv ====
module serial_regfile
   import core_pkg::*;
(
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_rf_rreq,
   input  logic              i_rf_wreq,
   input  logic              i_rd_en,
   input  logic [CNT_W-1:0]  i_cnt,
   input  logic [REG_AW-1:0] i_rs1,
   input  logic [REG_AW-1:0] i_rs2,
   input  logic [REG_AW-1:0] i_rd,
   input  logic              i_rd_bit,
   output logic              o_rf_ready,
   output logic              o_rs1_bit,
   output logic              o_rs2_bit
);

   logic [XLEN-1:0] regs [NUM_REGS];

   // One bit per cycle, x0 never written.
   always_ff @(posedge i_clk) begin
      if (i_rd_en && (i_rd != '0)) begin
         regs[i_rd][i_cnt] <= i_rd_bit;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_rf_ready <= 1'b0;
      end else begin
         o_rf_ready <= i_rf_rreq | i_rf_wreq;   // Answer any request next cycle.
      end
   end

   assign o_rs1_bit = (i_rs1 == '0) ? 1'b0 : regs[i_rs1][i_cnt];
   assign o_rs2_bit = (i_rs2 == '0) ? 1'b0 : regs[i_rs2][i_cnt];

endmodule

// ==== hdl/serial_alu.sv ====
module serial_alu
   import core_pkg::*;
(
   input  logic             i_clk,
   input  logic             i_rst,
   input  state_t           i_state,
   input  logic [CNT_W-1:0] i_cnt,
   input  logic             i_stage_two_pending,
   input  alu_op_t          i_alu_op,
   input  logic             i_rs1_bit,
   input  logic             i_op_b_bit,
   output logic             o_sh_done,
   output logic             o_rd_bit
);

   logic             sub;
   logic             b_eff;
   logic             carry_q;
   logic             carry_in;
   logic             sum;
   logic             carry_out;
   logic             lt_signed;
   logic             cmp_lt;
   logic             cmp_flag;
   logic             shifting;
   logic [XLEN-1:0]  sh_buf;
   logic [CNT_W-1:0] shamt;   // Same width as a shift amount.

   assign sub       = (i_alu_op == ALU_SUB) | (i_alu_op == ALU_SLT) | (i_alu_op == ALU_SLTU);
   assign b_eff     = i_op_b_bit ^ sub;
   assign carry_in  = (i_cnt == '0) ? sub : carry_q;   // +1 of the two's complement.
   assign sum       = i_rs1_bit ^ b_eff ^ carry_in;
   assign carry_out = (i_rs1_bit & b_eff) | (i_rs1_bit & carry_in) | (b_eff & carry_in);

   // Only meaningful on bit 31.
   assign lt_signed = (i_rs1_bit ^ i_op_b_bit) ? i_rs1_bit : sum;
   assign cmp_lt    = (i_alu_op == ALU_SLTU) ? !carry_out : lt_signed;

   assign shifting  = (i_state == IDLE) & i_stage_two_pending & (shamt != '0);
   assign o_sh_done = (shamt == '0);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry_q <= 1'b0;
         shamt   <= '0;
      end else begin
         carry_q <= carry_out;
         if ((i_state == INIT) && (i_cnt < CNT_W)) begin
            shamt[i_cnt[2:0]] <= i_op_b_bit;
         end else if (shifting) begin
            shamt <= shamt - 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_state == INIT) begin
         sh_buf <= {i_rs1_bit, sh_buf[XLEN-1:1]};   // Operand A in, LSB first.
         if (i_cnt == '1) begin
            cmp_flag <= cmp_lt;
         end
      end else if (shifting) begin
         case (i_alu_op)
            ALU_SLL: sh_buf <= {sh_buf[XLEN-2:0], 1'b0};
            ALU_SRA: sh_buf <= {sh_buf[XLEN-1], sh_buf[XLEN-1:1]};
            default: sh_buf <= {1'b0, sh_buf[XLEN-1:1]};
         endcase
      end
   end

   always_comb begin
      case (i_alu_op)
         ALU_ADD,
         ALU_SUB:  o_rd_bit = sum;
         ALU_AND:  o_rd_bit = i_rs1_bit & i_op_b_bit;
         ALU_OR:   o_rd_bit = i_rs1_bit | i_op_b_bit;
         ALU_XOR:  o_rd_bit = i_rs1_bit ^ i_op_b_bit;
         ALU_SLT,
         ALU_SLTU: o_rd_bit = (i_cnt == '0) & cmp_flag;   // Flag then zeros.
         default:  o_rd_bit = sh_buf[i_cnt];
      endcase
   end

endmodule

// ==== hdl/state_ctrl.sv ====
module state_ctrl
   import core_pkg::*;
(
   input  logic             i_clk,
   input  logic             i_rst,
   input  logic             i_irq,
   input  logic             i_ibus_ack,
   input  logic             i_rf_ready,
   input  logic             i_slt_op,
   input  logic             i_shift_op,
   input  logic             i_e_op,
   input  logic             i_rd_op,
   input  logic             i_alu_sh_done,
   output logic             o_ibus_cyc,
   output logic             o_trap_taken,
   output logic             o_rf_rreq,
   output logic             o_rf_wreq,
   output logic             o_rf_rd_en,
   output state_t           o_state,
   output logic [CNT_W-1:0] o_cnt,
   output logic [3:0]       o_cnt_r,
   output logic             o_cnt_done,
   output logic             o_stage_two_pending
);

   logic       cnt_en;
   logic       init;
   logic       idle;
   logic       two_stage_op;
   logic       stage_two_req;
   logic       ctrl_trap;
   logic       pending_irq;
   logic       irq_sync;
   logic [1:0] irq_meta;
   logic       irq_q;
   logic       new_irq;

   assign cnt_en       = (o_state != IDLE);
   assign init         = (o_state == INIT);
   assign idle         = (o_state == IDLE);
   assign two_stage_op = i_slt_op | i_shift_op;

   // Fetch only between instructions, not while the regfile answers.
   assign o_ibus_cyc = idle & !o_stage_two_pending & !i_rf_ready;

   assign o_rf_rreq = i_ibus_ack;   // Regfile prepares on every fetch.
   assign o_rf_wreq = (stage_two_req & i_slt_op) |
                      (i_shift_op & i_alu_sh_done & o_stage_two_pending & idle & !i_rf_ready);

   assign o_rf_rd_en = i_rd_op & (o_state == RUN);   // Traps write nothing.

   assign ctrl_trap    = i_e_op | pending_irq;
   assign o_trap_taken = i_ibus_ack & ctrl_trap;

   ////////////////////
   // Sequencer
   ////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_state             <= IDLE;
         o_cnt               <= '0;
         o_cnt_r             <= 4'b0001;
         o_cnt_done          <= 1'b0;
         o_stage_two_pending <= 1'b0;
         stage_two_req       <= 1'b0;
      end else begin
         if (o_cnt_done) begin
            o_state <= IDLE;
         end else if (i_rf_ready && !cnt_en) begin
            if (ctrl_trap) begin
               o_state <= TRAP;
            end else if (two_stage_op && !o_stage_two_pending) begin
               o_state <= INIT;
            end else begin
               o_state <= RUN;
            end
         end

         if (cnt_en) begin
            o_stage_two_pending <= init;                      // Set by INIT, cleared by RUN.
            o_cnt_r             <= {o_cnt_r[2:0], o_cnt_r[3]};
         end
         o_cnt <= o_cnt + CNT_W'(cnt_en);

         o_cnt_done    <= (o_cnt[CNT_W-1:2] == '1) & o_cnt_r[2];   // High during bit 31.
         stage_two_req <= o_cnt_done & init;                       // First IDLE cycle after INIT.
      end
   end

   ////////////////////
   // Interrupts
   ////////////////////

   assign new_irq = irq_meta[1] & !irq_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         irq_meta    <= '0;
         irq_q       <= 1'b0;
         irq_sync    <= 1'b0;
         pending_irq <= 1'b0;
      end else begin
         irq_meta <= {irq_meta[0], i_irq};
         irq_q    <= irq_meta[1];
         if (i_ibus_ack) begin
            irq_sync    <= 1'b0;
            pending_irq <= irq_sync;   // Taken at the instruction boundary.
         end
         if (new_irq) begin
            irq_sync <= 1'b1;
         end
      end
   end

endmodule

// ==== hdl/instr_decoder.sv ====
module instr_decoder
   import core_pkg::*;
(
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_ibus_ack,
   input  logic [31:0]       i_ibus_rdt,
   input  logic [CNT_W-1:0]  i_cnt,
   output alu_op_t           o_alu_op,
   output logic              o_imm_op,
   output logic              o_imm_bit,
   output logic [REG_AW-1:0] o_rs1,
   output logic [REG_AW-1:0] o_rs2,
   output logic [REG_AW-1:0] o_rd,
   output logic              o_rd_op,
   output logic              o_slt_op,
   output logic              o_shift_op,
   output logic              o_e_op
);

   localparam logic [6:0]  OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0]  OPC_OP     = 7'b0110011;
   localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
   localparam logic [31:0] INSN_NOP   = 32'h0000_0013;   // addi x0, x0, 0.

   logic [31:0] instr;
   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [11:0] imm12;
   logic        alu_class;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         instr <= INSN_NOP;
      end else if (i_ibus_ack) begin
         instr <= i_ibus_rdt;   // Held for the whole instruction.
      end
   end

   assign opcode    = instr[6:0];
   assign funct3    = instr[14:12];
   assign imm12     = instr[31:20];
   assign alu_class = (opcode == OPC_OP) | (opcode == OPC_OP_IMM);

   assign o_imm_op   = (opcode == OPC_OP_IMM);
   assign o_rd_op    = alu_class;
   assign o_slt_op   = alu_class & (funct3[2:1] == 2'b01);   // slt, sltu.
   assign o_shift_op = alu_class & (funct3[1:0] == 2'b01);   // sll, srl, sra.
   assign o_e_op     = (opcode == OPC_SYSTEM);

   // Register fields alias onto their low bits.
   assign o_rs1 = instr[15 +: REG_AW];
   assign o_rs2 = instr[20 +: REG_AW];
   assign o_rd  = instr[7 +: REG_AW];

   always_comb begin
      case (funct3)
         3'b000:  o_alu_op = ((opcode == OPC_OP) && instr[30]) ? ALU_SUB : ALU_ADD;
         3'b001:  o_alu_op = ALU_SLL;
         3'b010:  o_alu_op = ALU_SLT;
         3'b011:  o_alu_op = ALU_SLTU;
         3'b100:  o_alu_op = ALU_XOR;
         3'b101:  o_alu_op = instr[30] ? ALU_SRA : ALU_SRL;
         3'b110:  o_alu_op = ALU_OR;
         default: o_alu_op = ALU_AND;
      endcase
   end

   // Sign-extended I-immediate, LSB first. Shift amounts keep only five bits.
   always_comb begin
      if (o_shift_op && (i_cnt >= 5)) begin
         o_imm_bit = 1'b0;
      end else if (i_cnt < 12) begin
         o_imm_bit = imm12[i_cnt[3:0]];
      end else begin
         o_imm_bit = imm12[11];   // Sign fill.
      end
   end

endmodule

// ==== hdl/core_pkg.sv ====
package core_pkg;

   ////////////////////
   // Sizes
   ////////////////////

   localparam int XLEN     = 32;   // Data word width.
   localparam int CNT_W    = 5;    // Bit counter, one pass is 2**CNT_W cycles.
   localparam int REG_AW   = 3;    // Register number width.
   localparam int NUM_REGS = 8;    // x0 to x7.

   ////////////////////
   // Sequencer states
   ////////////////////

   typedef enum logic [1:0] {
      IDLE = 2'd0,    // Waiting for fetch or between stages.
      INIT = 2'd1,    // Stage one of compare and shift.
      RUN  = 2'd2,    // Result pass.
      TRAP = 2'd3     // Trap pass, nothing written.
   } state_t;

   ////////////////////
   // ALU operations
   ////////////////////

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_AND  = 4'd2,
      ALU_OR   = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_SLT  = 4'd5,
      ALU_SLTU = 4'd6,
      ALU_SLL  = 4'd7,
      ALU_SRL  = 4'd8,
      ALU_SRA  = 4'd9
   } alu_op_t;

endpackage
